// ==== common/boot_defs.svh ====
//
// boot copy configuration
// startup delay, copy length and the flash read command
//
`ifndef BOOT_DEFS_SVH
`define BOOT_DEFS_SVH

// ------------------------------------------------
// startup
// ------------------------------------------------

// idle clock cycles after reset before the flash is opened
`define STARTUP_WAIT_CYCLES 20

// ------------------------------------------------
// flash copy
// ------------------------------------------------

// bytes copied into burst RAM
// not a multiple of 8 so the last line goes out masked
`define FLASH_TRANSFER_BYTE_COUNT 44

`define FLASH_BASE_ADDR 24'h000000  // first flash byte read
`define FLASH_READ_CMD 8'h03  // plain SPI read, no dummy cycles

`endif

// ==== common/boot_pkg.sv ====
//
// boot control types
// sequencer states, counter values and the flash byte
//
`default_nettype none

package boot_pkg;

  // ------------------------------------------------
  // sequencer
  // ------------------------------------------------

  // boot sequence, one pass after reset
  typedef enum logic [2:0] {
    boot_wait,    // startup delay running
    boot_start,   // open flash, first request
    boot_stream,  // byte by byte copy
    boot_flush,   // push out partial last line
    boot_done     // copy finished, parked here
  } boot_state_e;

  // ------------------------------------------------
  // counting and data
  // ------------------------------------------------

  // startup cycles and remaining bytes share this width
  typedef logic [15:0] count_t;

  // one byte from flash_spi_reader to line_packer
  typedef logic [7:0] flash_byte_t;

endpackage

`default_nettype wire

// ==== common/mem_pkg.sv ====
//
// burst RAM types
// one 64-bit line per command, byte mask, byte address
//
`default_nettype none

package mem_pkg;

  // ------------------------------------------------
  // line layout
  // ------------------------------------------------

  // byte k of a line sits at bits 8k+7:8k
  typedef logic [63:0] line_data_t;

  // one bit per byte, 1 = byte left untouched
  typedef logic [7:0] line_mask_t;

  typedef logic [20:0] ram_addr_t;  // byte address

  // ------------------------------------------------
  // command
  // ------------------------------------------------

  // a single cycle with cmd_en high is one whole write
  // no ready from the RAM side
  typedef struct packed {
    logic cmd;               // 0: read, 1: write
    logic cmd_en;            // command valid this cycle
    ram_addr_t addr;         // line aligned
    line_data_t wr_data;
    line_mask_t data_mask;
  } br_req_t;

endpackage

`default_nettype wire

// ==== hdl/cycle_timer.sv ====
//
// loadable down counter
// counts to zero and parks there, zero flag while empty
//
`default_nettype none

module cycle_timer (
  input wire clk,
  input wire rst_n,

  input wire load,  // takes load_value this cycle
  input wire boot_pkg::count_t load_value,
  output logic zero
);

  import boot_pkg::*;

  count_t count_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;  // starts empty
    end else if (load) begin
      count_q <= load_value;  // load wins over decrement
    end else if (count_q != '0) begin
      count_q <= count_q - count_t'(1);
    end
  end

  // high in the cycle right after loading 0
  assign zero = (count_q == '0);

endmodule

`default_nettype wire

// ==== hdl/boot_fsm.sv ====
//
// boot sequencer
// startup wait, byte requests to the flash reader with back-pressure
// from the packer, final flush and the done flag
//
`default_nettype none
`include "boot_defs.svh"

module boot_fsm (
  input wire clk,
  input wire rst_n,

  output logic timer_load,
  output boot_pkg::count_t timer_value,
  input wire timer_zero,

  output logic flash_active,  // keeps chip select low
  output logic byte_req,      // one cycle pulse
  input wire byte_valid,
  input wire packer_busy,     // line write this cycle
  output logic flush,
  output logic boot_done
);

  import boot_pkg::*;

  boot_state_e state_q;
  logic armed_q;  // startup wait loaded
  logic check_q;  // cycle after an accepted byte
  logic hold_q;   // next request stalled by a write
  count_t bytes_left_q;
  logic last_byte;
  logic req_due;

  // timer was reloaded with the remaining count on the byte, so
  // zero here means that byte was the last one
  assign last_byte = check_q && timer_zero;
  assign req_due = (check_q && !timer_zero) || hold_q;

  // ------------------------------------------------
  // timer control
  // ------------------------------------------------
  always_comb begin
    timer_load = 1'b0;
    timer_value = count_t'(`STARTUP_WAIT_CYCLES - 1);  // first load lands one cycle late
    case (state_q)
      boot_wait: timer_load = !armed_q;
      boot_start: begin
        timer_load = 1'b1;
        timer_value = count_t'(`FLASH_TRANSFER_BYTE_COUNT);
      end
      boot_stream: begin
        timer_load = byte_valid;  // count down per byte
        timer_value = bytes_left_q - count_t'(1);
      end
      default: ;
    endcase
  end

  assign flash_active = (state_q == boot_start) || (state_q == boot_stream);
  // next request only once the packer is not writing
  assign byte_req = (state_q == boot_start) ||
                    ((state_q == boot_stream) && req_due && !packer_busy);
  // boot_done the port hides the enum literal of the same name
  assign boot_done = (state_q == boot_pkg::boot_done);

  // ------------------------------------------------
  // state
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= boot_wait;
      armed_q <= 1'b0;
      check_q <= 1'b0;
      hold_q <= 1'b0;
      flush <= 1'b0;
      bytes_left_q <= '0;
    end else begin
      check_q <= 1'b0;
      flush <= 1'b0;  // single pulse
      case (state_q)
        boot_wait: begin
          armed_q <= 1'b1;
          if (armed_q && timer_zero) state_q <= boot_start;
        end
        boot_start: begin
          bytes_left_q <= count_t'(`FLASH_TRANSFER_BYTE_COUNT);
          state_q <= boot_stream;
        end
        boot_stream: begin
          if (byte_valid) begin
            check_q <= 1'b1;
            bytes_left_q <= bytes_left_q - count_t'(1);
          end
          hold_q <= req_due && packer_busy;
          if (last_byte) begin
            // full last line is being written right now
            if ((`FLASH_TRANSFER_BYTE_COUNT % 8) != 0) begin
              state_q <= boot_flush;
              flush <= 1'b1;
            end else begin
              state_q <= boot_pkg::boot_done;
            end
          end
        end
        boot_flush: if (packer_busy) state_q <= boot_pkg::boot_done;  // masked write seen
        default: ;  // done, stay
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== flash/flash_spi_reader.sv ====
//
// SPI flash reader in mode 0 with SCK at half the clock rate
// sends read opcode and 24-bit address, then one byte per request
//
`default_nettype none
`include "boot_defs.svh"

module flash_spi_reader (
  input wire clk,
  input wire rst_n,

  input wire flash_active,
  input wire byte_req,
  output logic byte_valid,
  output boot_pkg::flash_byte_t byte_data,

  output logic flash_clk,
  output logic flash_cs_n,
  output logic flash_mosi,
  input wire flash_miso
);

  import boot_pkg::*;

  logic xfer_q;  // bits still to clock
  logic hdr_q;   // header phase so nothing to hand out
  logic pend_q;  // request parked behind the header
  logic [5:0] bits_q;
  logic [31:0] tx_q;
  flash_byte_t rx_q;
  logic open_frame;
  logic sample;
  logic shift;

  assign open_frame = flash_active && flash_cs_n;
  // rising SCK edge where miso is stable since the last falling one
  assign sample = flash_active && !flash_cs_n && xfer_q && !flash_clk;
  // falling SCK edge moves mosi on
  assign shift = flash_active && !flash_cs_n && xfer_q && flash_clk && (bits_q != '0);

  // ------------------------------------------------
  // control
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flash_cs_n <= 1'b1;
      flash_clk <= 1'b0;
      flash_mosi <= 1'b0;
      xfer_q <= 1'b0;
      hdr_q <= 1'b0;
      pend_q <= 1'b0;
      bits_q <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (byte_req) pend_q <= 1'b1;
      if (!flash_active) begin  // frame closed
        flash_cs_n <= 1'b1;
        flash_clk <= 1'b0;
        flash_mosi <= 1'b0;
        xfer_q <= 1'b0;
        pend_q <= 1'b0;
      end else if (open_frame) begin
        flash_cs_n <= 1'b0;
        flash_mosi <= 1'(`FLASH_READ_CMD >> 7);  // opcode msb first
        xfer_q <= 1'b1;
        hdr_q <= 1'b1;
        bits_q <= 6'd32;  // opcode + address
      end else if (sample) begin
        flash_clk <= 1'b1;
        bits_q <= bits_q - 6'd1;
        if (!hdr_q && bits_q == 6'd1) byte_valid <= 1'b1;
      end else if (shift) begin
        flash_clk <= 1'b0;
        flash_mosi <= tx_q[31];
      end else begin
        // idle, or last falling edge of header or byte
        flash_clk <= 1'b0;
        flash_mosi <= 1'b0;
        xfer_q <= byte_req || pend_q;
        if (byte_req || pend_q) begin
          hdr_q <= 1'b0;
          bits_q <= 6'd8;
          pend_q <= 1'b0;
        end
      end
    end
  end

  // ------------------------------------------------
  // shift registers
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (open_frame) tx_q <= {`FLASH_READ_CMD, `FLASH_BASE_ADDR} << 1;
    else if (shift) tx_q <= {tx_q[30:0], 1'b0};
    if (sample) rx_q <= {rx_q[6:0], flash_miso};
    if (sample && !hdr_q && bits_q == 6'd1) byte_data <= {rx_q[6:0], flash_miso};
  end

endmodule

`default_nettype wire

// ==== hdl/line_packer.sv ====
//
// line packer
// collects flash bytes little endian into a 64-bit line and writes
// each line to burst RAM, last partial line with its byte mask set
//
`default_nettype none

module line_packer (
  input wire clk,
  input wire rst_n,

  input wire byte_valid,
  input wire boot_pkg::flash_byte_t byte_data,
  input wire flush,  // write whatever is held

  output logic busy,  // write going out this cycle
  output mem_pkg::br_req_t br_req
);

  import mem_pkg::*;

  logic [2:0] fill_q;  // bytes held, wraps at 8
  logic wr_q;
  ram_addr_t line_addr_q;  // address of the next write
  line_data_t line_q;
  line_mask_t mask_q;
  line_mask_t lane_valid;
  line_data_t wr_data;

  // bytes 0 .. fill-1 hold data
  assign lane_valid = (line_mask_t'(1) << fill_q) - line_mask_t'(1);

  // ------------------------------------------------
  // fill level and write strobe
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_q <= '0;
      wr_q <= 1'b0;
      line_addr_q <= '0;
    end else begin
      wr_q <= 1'b0;
      if (wr_q) line_addr_q <= line_addr_q + ram_addr_t'(8);  // step after each line
      if (byte_valid) begin
        fill_q <= fill_q + 3'd1;
        if (fill_q == 3'd7) wr_q <= 1'b1;  // eighth byte
      end else if (flush) begin
        fill_q <= '0;
        wr_q <= 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // line data
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (byte_valid) line_q[{fill_q, 3'b000} +: 8] <= byte_data;
    if (byte_valid && fill_q == 3'd7) begin
      mask_q <= '0;  // full line
    end else if (flush) begin
      mask_q <= ~lane_valid;  // bytes never filled
    end
  end

  // masked lanes go out as zero instead of stale bytes
  always_comb begin
    for (int k = 0; k < 8; k++) begin
      wr_data[8*k +: 8] = mask_q[k] ? 8'h00 : line_q[8*k +: 8];
    end
  end

  assign busy = wr_q;
  assign br_req = '{
    cmd: 1'b1,  // writes only
    cmd_en: wr_q,
    addr: line_addr_q,
    wr_data: wr_data,
    data_mask: mask_q
  };

endmodule

`default_nettype wire

// ==== hdl/boot_top.sv ====
//
// boot copy top level
// copies the start of SPI flash into burst RAM after reset
//
`default_nettype none

module boot_top (
  input wire clk,
  input wire rst_n,

  output logic [5:0] led,

  output logic flash_clk,
  input wire flash_miso,
  output logic flash_mosi,
  output logic flash_cs_n,

  // burst RAM wiring, write side only
  output logic br_cmd,  // 1: write
  output logic br_cmd_en,
  output mem_pkg::ram_addr_t br_addr,
  output mem_pkg::line_data_t br_wr_data,
  output mem_pkg::line_mask_t br_data_mask
);

  import boot_pkg::*;
  import mem_pkg::*;

  // ------------------------------------------------
  // sequencing
  // ------------------------------------------------
  logic timer_load;
  count_t timer_value;
  logic timer_zero;
  logic flash_active;
  logic byte_req;
  logic byte_valid;
  flash_byte_t byte_data;
  logic flush;
  logic packer_busy;
  logic boot_done;
  br_req_t br_req;

  cycle_timer cycle_timer (
    .clk,
    .rst_n,
    .load(timer_load),
    .load_value(timer_value),
    .zero(timer_zero)
  );

  boot_fsm boot_fsm (
    .clk,
    .rst_n,
    .timer_load,
    .timer_value,
    .timer_zero,
    .flash_active,
    .byte_req,
    .byte_valid,
    .packer_busy,
    .flush,
    .boot_done
  );

  // ------------------------------------------------
  // data path
  // ------------------------------------------------
  flash_spi_reader flash_spi_reader (
    .clk,
    .rst_n,
    .flash_active,
    .byte_req,
    .byte_valid,
    .byte_data,
    .flash_clk,
    .flash_cs_n,
    .flash_mosi,
    .flash_miso
  );

  line_packer line_packer (
    .clk,
    .rst_n,
    .byte_valid,
    .byte_data,
    .flush,
    .busy(packer_busy),
    .br_req
  );

  // struct out to the br_ pins
  assign br_cmd = br_req.cmd;
  assign br_cmd_en = br_req.cmd_en;
  assign br_addr = br_req.addr;
  assign br_wr_data = br_req.wr_data;
  assign br_data_mask = br_req.data_mask;

  assign led[0] = boot_done;
  assign led[4:1] = br_req.addr[6:3];  // line number, low nibble
  assign led[5] = ~packer_busy;

endmodule

`default_nettype wire

// ==== verif/tb_models.sv ====
//
// testbench models
// SPI flash answering a plain read and a burst RAM write monitor
//
`default_nettype none

// ------------------------------------------------
// SPI flash in mode 0 with the read command only
// ------------------------------------------------
module flash_model (
  input wire sck,
  input wire cs_n,
  input wire mosi,
  output logic miso,
  output logic hdr_seen,  // sticky once 32 header bits are in
  output logic [7:0] hdr_cmd,
  output logic [23:0] hdr_addr
);

  logic [7:0] mem [256];  // image repeats every 256 bytes
  int seed;
  int bit_cnt = 0;  // rising SCK edges in this frame
  int pos;
  logic [31:0] hdr_q = '0;

  initial begin
    seed = 32'h765047e9;
    miso = 1'b0;
    hdr_seen = 1'b0;
    for (int a = 0; a < 256; a++) begin
      mem[a] = 8'($random(seed)) ^ 8'(a * 29);  // address mixed into every byte
    end
  end

  // opcode and address come in msb first on rising SCK
  always @(posedge sck or posedge cs_n) begin
    if (cs_n) begin
      bit_cnt <= 0;  // frame closed
    end else begin
      if (bit_cnt < 32) hdr_q <= {hdr_q[30:0], mosi};
      if (bit_cnt == 31) hdr_seen <= 1'b1;
      bit_cnt <= bit_cnt + 1;
    end
  end

  // data moves on falling SCK with sequential bytes from the decoded address
  always @(negedge sck) begin
    if (!cs_n && bit_cnt >= 32) begin
      pos = bit_cnt - 32;
      miso <= mem[8'(hdr_q[23:0] + pos / 8)][7 - pos % 8];
    end
  end

  assign hdr_cmd = hdr_q[31:24];
  assign hdr_addr = hdr_q[23:0];

endmodule

// ------------------------------------------------
// burst RAM write monitor
// ------------------------------------------------
module br_monitor (
  input wire clk,
  input wire rst_n,
  input wire cmd_en,
  input wire mem_pkg::ram_addr_t addr,
  output int write_count
);

  import mem_pkg::*;

  localparam int LOG_DEPTH = 64;

  ram_addr_t addr_log [LOG_DEPTH];

  // one entry per cycle with cmd_en high
  always @(posedge clk) begin
    if (!rst_n) begin
      write_count <= 0;
    end else if (cmd_en) begin
      if (write_count < LOG_DEPTH) begin
        addr_log[write_count] <= addr;
      end
      write_count <= write_count + 1;
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_boot_top.sv ====
//
// boot_top testbench
// flash model feeds the copy and burst RAM writes are checked
// line by line against the flash image
//
`default_nettype none
`include "boot_defs.svh"

module tb_boot_top;

  import mem_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DELAY = 10;  // after the rising edge
  localparam int SELECT_TIMEOUT = `STARTUP_WAIT_CYCLES + 40;
  localparam int DONE_TIMEOUT = 4000;
  localparam int QUIET_CYCLES = 200;
  localparam int LINE_COUNT = (`FLASH_TRANSFER_BYTE_COUNT + 7) / 8;

  logic clk;
  logic rst_n;
  logic [5:0] led;
  logic flash_clk;
  logic flash_miso;
  logic flash_mosi;
  logic flash_cs_n;
  logic br_cmd;
  logic br_cmd_en;
  ram_addr_t br_addr;
  line_data_t br_wr_data;
  line_mask_t br_data_mask;

  logic hdr_seen;
  logic [7:0] hdr_cmd;
  logic [23:0] hdr_addr;
  int write_count;
  int cycle_idx = -1;  // last edge where 0 is the first with rst_n high
  line_data_t exp_line;
  line_data_t keep;  // lanes that carry flash data
  line_mask_t exp_mask;
  string log_error;

  always #50 clk = ~clk;

  boot_top dut_i (
    .clk, .rst_n, .led,
    .flash_clk, .flash_miso, .flash_mosi, .flash_cs_n,
    .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask
  );

  flash_model flash_model_i (
    .sck(flash_clk), .cs_n(flash_cs_n), .mosi(flash_mosi), .miso(flash_miso),
    .hdr_seen, .hdr_cmd, .hdr_addr
  );

  br_monitor br_monitor_i (
    .clk, .rst_n, .cmd_en(br_cmd_en), .addr(br_addr), .write_count
  );

  always @(posedge clk) begin
    if (!rst_n) cycle_idx <= -1;
    else cycle_idx <= cycle_idx + 1;
  end

  // expected line at the current write address with bytes past the count masked
  always_comb begin
    for (int k = 0; k < 8; k++) begin
      exp_mask[k] = (int'(br_addr) + k) >= `FLASH_TRANSFER_BYTE_COUNT;
      exp_line[8*k +: 8] = flash_model_i.mem[8'(`FLASH_BASE_ADDR + int'(br_addr) + k)];
      keep[8*k +: 8] = exp_mask[k] ? 8'h00 : 8'hff;
    end
  end

  // ------------------------------------------------
  // reporting
  // ------------------------------------------------
  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_value(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    $display("FAILED %s expected %0h actual %0h", name, expected, actual);
    stop_run();
  endtask

  task automatic fail_text(input string what);
    $display("ERROR %s", what);
    stop_run();
  endtask

  // ------------------------------------------------
  // checks sampled mid cycle
  // ------------------------------------------------
  startup_cs_high: assert property (@(negedge clk) disable iff (!rst_n)
    cycle_idx <= `STARTUP_WAIT_CYCLES |-> flash_cs_n)
    else fail_value("startup_cs_high", 64'd1, 64'(flash_cs_n));
  startup_no_write: assert property (@(negedge clk) disable iff (!rst_n)
    cycle_idx <= `STARTUP_WAIT_CYCLES |-> !br_cmd_en)
    else fail_value("startup_no_write", 64'd0, 64'(br_cmd_en));
  startup_led: assert property (@(negedge clk) disable iff (!rst_n)
    cycle_idx <= `STARTUP_WAIT_CYCLES |-> led == 6'b100000)  // idle only
    else fail_value("startup_led", 64'h20, 64'(led));
  select_time: assert property (@(negedge clk) disable iff (!rst_n)
    cycle_idx == `STARTUP_WAIT_CYCLES + 1 |-> !flash_cs_n)
    else fail_value("select_time", 64'd0, 64'(flash_cs_n));

  header_cmd: assert property (@(negedge clk) disable iff (!rst_n)
    hdr_seen |-> hdr_cmd == `FLASH_READ_CMD)
    else fail_value("header_cmd", 64'(`FLASH_READ_CMD), 64'(hdr_cmd));
  header_addr: assert property (@(negedge clk) disable iff (!rst_n)
    hdr_seen |-> hdr_addr == `FLASH_BASE_ADDR)
    else fail_value("header_addr", 64'(`FLASH_BASE_ADDR), 64'(hdr_addr));

  write_cmd: assert property (@(negedge clk) disable iff (!rst_n)
    br_cmd_en |-> br_cmd)
    else fail_value("write_cmd", 64'd1, 64'(br_cmd));
  write_addr: assert property (@(negedge clk) disable iff (!rst_n)
    br_cmd_en |-> br_addr == ram_addr_t'(8 * write_count))  // count of earlier writes
    else fail_value("write_addr", 64'(8 * write_count), 64'(br_addr));
  write_mask: assert property (@(negedge clk) disable iff (!rst_n)
    br_cmd_en |-> br_data_mask == exp_mask)
    else fail_value("write_mask", 64'(exp_mask), 64'(br_data_mask));
  write_data: assert property (@(negedge clk) disable iff (!rst_n)
    br_cmd_en |-> (br_wr_data & keep) == (exp_line & keep))
    else fail_value("write_data", exp_line & keep, br_wr_data & keep);

  // line number low nibble on the LEDs while its write goes out
  write_led: assert property (@(negedge clk) disable iff (!rst_n)
    br_cmd_en |-> led[4:1] == 4'(write_count))
    else fail_value("write_led", 64'(4'(write_count)), 64'(led[4:1]));
  busy_led: assert property (@(negedge clk) disable iff (!rst_n)
    led[5] == !br_cmd_en)  // packer busy only in a write cycle
    else fail_value("busy_led", 64'(!br_cmd_en), 64'(led[5]));

  done_after_write: assert property (@(negedge clk) disable iff (!rst_n)
    $rose(led[0]) |-> $past(br_cmd_en))
    else fail_text("boot_done did not follow the final write by one cycle");
  quiet_after_done: assert property (@(negedge clk) disable iff (!rst_n)
    led[0] |-> !br_cmd_en)
    else fail_value("quiet_after_done", 64'd0, 64'(br_cmd_en));

  // ------------------------------------------------
  // sequence
  // ------------------------------------------------
  task automatic wait_flash_select();
    int n;
    n = 0;
    while (flash_cs_n !== 1'b0 && n < SELECT_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (flash_cs_n !== 1'b0) fail_text("flash chip select never went low");
  endtask

  task automatic wait_boot_done();
    int n;
    n = 0;
    while (led[0] !== 1'b1 && n < DONE_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (led[0] !== 1'b1) fail_text("boot_done LED never came on");
  endtask

  // first problem in the write log, empty when the log is right
  function automatic string write_log_error();
    if (write_count != LINE_COUNT) begin
      return $sformatf("FAILED line_count expected %0d actual %0d",
                       LINE_COUNT, write_count);
    end
    for (int i = 0; i < LINE_COUNT; i++) begin
      if (br_monitor_i.addr_log[i] != ram_addr_t'(8 * i)) begin
        return $sformatf("FAILED line_addr_seq expected %0h actual %0h",
                         8 * i, br_monitor_i.addr_log[i]);
      end
    end
    if (!hdr_seen) return "ERROR flash model never received a full read header";
    return "";
  endfunction

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY rst_n = 1'b1;
    wait_flash_select();
    wait_boot_done();
    repeat (QUIET_CYCLES) @(negedge clk);  // quiet_after_done watching
    log_error = write_log_error();
    if (log_error == "") begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("%s", log_error);
      stop_run();
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/boot_pkg.sv
common/mem_pkg.sv
hdl/cycle_timer.sv
hdl/boot_fsm.sv
flash/flash_spi_reader.sv
hdl/line_packer.sv
hdl/boot_top.sv
verif/tb_models.sv
verif/tb_boot_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   := sources.f
TOP        := tb_boot_top
RTL_TOP    := boot_top
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status of the simulation binary is the test result
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
